// ==== rtl/div_pkg.sv ====
package div_pkg;

  // datapath width fixed by RV64
  localparam int XLEN     = 64;
  localparam int WORD_LEN = 32;
  localparam int CNT_W    = $clog2(XLEN);

  localparam int AXIL_AW = 8;
  localparam int AXIL_DW = 32;

  // register map, byte offsets
  localparam logic [AXIL_AW-1:0] REG_CTRL   = 8'h00;
  localparam logic [AXIL_AW-1:0] REG_STATUS = 8'h04;
  localparam logic [AXIL_AW-1:0] REG_A_LO   = 8'h08;
  localparam logic [AXIL_AW-1:0] REG_A_HI   = 8'h0C;
  localparam logic [AXIL_AW-1:0] REG_B_LO   = 8'h10;
  localparam logic [AXIL_AW-1:0] REG_B_HI   = 8'h14;
  localparam logic [AXIL_AW-1:0] REG_RES_LO = 8'h18;
  localparam logic [AXIL_AW-1:0] REG_RES_HI = 8'h1C;

  // control and status bit positions
  localparam int CTRL_START_BIT = 8;
  localparam int ST_BUSY_BIT    = 0;
  localparam int ST_DONE_BIT    = 1;
  localparam int ST_REJECT_BIT  = 2;

  // bit 2 is_signed, bit 1 is_word, bit 0 want_rem
  typedef struct packed {
    logic is_signed;
    logic is_word;
    logic want_rem;
  } div_op_t;

  typedef struct packed {
    div_op_t         op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
  } div_req_t;

  typedef struct packed {
    div_op_t         op;
    logic [XLEN-1:0] dividend_abs;
    logic [XLEN-1:0] divisor_abs;
    logic            neg_quot;
    logic            neg_rem;
    logic            div_zero;
    logic            overflow;
    // extended dividend as seen by the ISA, used by the special cases
    logic [XLEN-1:0] dividend;
  } div_operands_t;

  typedef struct packed {
    div_op_t         op;
    logic [XLEN-1:0] quotient;
    logic [XLEN-1:0] remainder;
    logic            neg_quot;
    logic            neg_rem;
    logic            div_zero;
    logic            overflow;
    logic [XLEN-1:0] dividend;
  } div_raw_t;

  typedef logic [XLEN-1:0] div_result_t;

endpackage

// ==== rtl/div_axil_regs.sv ====
`timescale 1ns/100ps

module div_axil_regs
  import div_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic [AXIL_AW-1:0] i_awaddr,
  input  logic               i_awvalid,
  output logic               o_awready,
  input  logic [AXIL_DW-1:0] i_wdata,
  input  logic [3:0]         i_wstrb,
  input  logic               i_wvalid,
  output logic               o_wready,
  output logic [1:0]         o_bresp,
  output logic               o_bvalid,
  input  logic               i_bready,
  input  logic [AXIL_AW-1:0] i_araddr,
  input  logic               i_arvalid,
  output logic               o_arready,
  output logic [AXIL_DW-1:0] o_rdata,
  output logic [1:0]         o_rresp,
  output logic               o_rvalid,
  input  logic               i_rready,
  output logic               o_req_valid,
  input  logic               i_req_ready,
  output div_req_t           o_req,
  input  logic               i_res_valid,
  output logic               o_res_ready,
  input  div_result_t        i_res
);

  logic [AXIL_DW-1:0] a_lo, a_hi, b_lo, b_hi;
  logic [AXIL_DW-1:0] rd_data;
  div_op_t            ctrl_op;
  div_result_t        res_r;
  logic               busy, done, reject;
  logic               wr_en, wr_full, start_wr, launch, rd_en;

  // address and data are taken together, one write outstanding at a time
  assign o_awready = i_awvalid && i_wvalid && !o_bvalid;
  assign o_wready  = o_awready;
  assign wr_en     = o_awready;
  // partial strobes drop the whole word
  assign wr_full   = wr_en && (&i_wstrb);
  assign start_wr  = wr_full && (i_awaddr == REG_CTRL) && i_wdata[CTRL_START_BIT];
  assign launch    = start_wr && !busy;

  assign o_arready = !o_rvalid;
  assign rd_en     = i_arvalid && o_arready;

  assign o_bresp     = 2'b00;
  assign o_rresp     = 2'b00;
  assign o_res_ready = 1'b1;

  always_comb begin
    rd_data = '0;
    case (i_araddr)
      REG_CTRL:   rd_data[$bits(div_op_t)-1:0] = ctrl_op;
      REG_STATUS: begin
        rd_data[ST_BUSY_BIT]   = busy;
        rd_data[ST_DONE_BIT]   = done;
        rd_data[ST_REJECT_BIT] = reject;
      end
      REG_A_LO:   rd_data = a_lo;
      REG_A_HI:   rd_data = a_hi;
      REG_B_LO:   rd_data = b_lo;
      REG_B_HI:   rd_data = b_hi;
      REG_RES_LO: rd_data = res_r[AXIL_DW-1:0];
      REG_RES_HI: rd_data = res_r[XLEN-1:AXIL_DW];
      default:    rd_data = '0;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ctrl_op     <= '0;
      busy        <= 1'b0;
      done        <= 1'b0;
      reject      <= 1'b0;
      o_req_valid <= 1'b0;
      o_bvalid    <= 1'b0;
      o_rvalid    <= 1'b0;
      res_r       <= '0;
    end else begin
      if (wr_full && (i_awaddr == REG_CTRL)) begin
        ctrl_op <= div_op_t'(i_wdata[$bits(div_op_t)-1:0]);
      end
      if (wr_en) begin
        o_bvalid <= 1'b1;
      end else if (i_bready) begin
        o_bvalid <= 1'b0;
      end
      if (rd_en) begin
        o_rvalid <= 1'b1;
      end else if (i_rready) begin
        o_rvalid <= 1'b0;
      end
      // a reject raised in the same cycle as a STATUS read survives the read
      if (start_wr && busy) begin
        reject <= 1'b1;
      end else if (rd_en && (i_araddr == REG_STATUS)) begin
        reject <= 1'b0;
      end
      if (launch) begin
        o_req_valid <= 1'b1;
      end else if (i_req_ready) begin
        o_req_valid <= 1'b0;
      end
      if (launch) begin
        busy <= 1'b1;
        done <= 1'b0;
      end else if (i_res_valid) begin
        busy  <= 1'b0;
        done  <= 1'b1;
        res_r <= i_res;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (wr_full) begin
      case (i_awaddr)
        REG_A_LO: a_lo <= i_wdata;
        REG_A_HI: a_hi <= i_wdata;
        REG_B_LO: b_lo <= i_wdata;
        REG_B_HI: b_hi <= i_wdata;
        default: ;
      endcase
    end
    // the request is latched at launch so later operand writes cannot disturb it
    if (launch) begin
      o_req.op <= div_op_t'(i_wdata[$bits(div_op_t)-1:0]);
      o_req.a  <= {a_hi, a_lo};
      o_req.b  <= {b_hi, b_lo};
    end
    if (rd_en) begin
      o_rdata <= rd_data;
    end
  end

endmodule

// ==== rtl/div_operand_prep.sv ====
`timescale 1ns/100ps

module div_operand_prep
  import div_pkg::*;
(
  input  logic          i_clk,
  input  logic          i_rst_n,
  input  logic          i_req_valid,
  output logic          o_req_ready,
  input  div_req_t      i_req,
  output logic          o_opr_valid,
  input  logic          i_opr_ready,
  output div_operands_t o_opr
);

  logic [XLEN-1:0] a_ext, b_ext;
  logic [XLEN-1:0] min_neg;
  logic            a_neg, b_neg;
  logic            accept;
  div_operands_t   opr_next;

  // word forms only look at the low half, extended by signedness
  function automatic logic [XLEN-1:0] extend_word(input logic [XLEN-1:0] v,
                                                  input div_op_t op);
    logic fill;
    fill = op.is_signed & v[WORD_LEN-1];
    if (op.is_word) begin
      return {{(XLEN-WORD_LEN){fill}}, v[WORD_LEN-1:0]};
    end
    return v;
  endfunction

  assign o_req_ready = !o_opr_valid || i_opr_ready;
  assign accept      = i_req_valid && o_req_ready;

  assign a_ext = extend_word(i_req.a, i_req.op);
  assign b_ext = extend_word(i_req.b, i_req.op);

  assign a_neg = i_req.op.is_signed && a_ext[XLEN-1];
  assign b_neg = i_req.op.is_signed && b_ext[XLEN-1];

  // most negative value for the width, already sign-extended to XLEN
  assign min_neg = i_req.op.is_word ?
                   {{(XLEN-WORD_LEN+1){1'b1}}, {(WORD_LEN-1){1'b0}}} :
                   {1'b1, {(XLEN-1){1'b0}}};

  always_comb begin
    opr_next.op           = i_req.op;
    opr_next.dividend_abs = a_neg ? (~a_ext + 1'b1) : a_ext;
    opr_next.divisor_abs  = b_neg ? (~b_ext + 1'b1) : b_ext;
    opr_next.neg_quot     = a_neg ^ b_neg;
    opr_next.neg_rem      = a_neg;
    opr_next.div_zero     = (b_ext == '0);
    opr_next.overflow     = i_req.op.is_signed && (a_ext == min_neg) && (&b_ext);
    opr_next.dividend     = a_ext;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_opr_valid <= 1'b0;
    end else if (accept) begin
      o_opr_valid <= 1'b1;
    end else if (i_opr_ready) begin
      o_opr_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_opr <= opr_next;
    end
  end

endmodule

// ==== rtl/div_iter_core.sv ====
`timescale 1ns/100ps

module div_iter_core
  import div_pkg::*;
(
  input  logic          i_clk,
  input  logic          i_rst_n,
  input  logic          i_opr_valid,
  output logic          o_opr_ready,
  input  div_operands_t i_opr,
  output logic          o_raw_valid,
  input  logic          i_raw_ready,
  output div_raw_t      o_raw
);

  // bit position of the dividend being brought down this cycle
  logic [CNT_W-1:0] cnt;
  logic             running;
  logic             accept;
  div_operands_t    opr_r;
  logic [XLEN-1:0]  quot_r;
  logic [XLEN-1:0]  rem_r;
  logic [XLEN:0]    trial;
  logic [XLEN:0]    diff;
  logic             fits;

  assign o_opr_ready = !running && !o_raw_valid;
  assign accept      = i_opr_valid && o_opr_ready;

  // partial remainder shifted up with the next dividend bit appended
  assign trial = {rem_r, opr_r.dividend_abs[cnt]};
  assign diff  = trial - {1'b0, opr_r.divisor_abs};
  // no borrow means the divisor fits into the partial remainder
  assign fits  = !diff[XLEN];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      running     <= 1'b0;
      o_raw_valid <= 1'b0;
      cnt         <= '0;
    end else begin
      if (accept) begin
        running <= 1'b1;
        // word operands have nothing above bit 31 so we start there
        cnt     <= i_opr.op.is_word ? CNT_W'(WORD_LEN-1) : CNT_W'(XLEN-1);
      end else if (running) begin
        cnt <= cnt - 1'b1;
        if (cnt == '0) begin
          running     <= 1'b0;
          o_raw_valid <= 1'b1;
        end
      end else if (o_raw_valid && i_raw_ready) begin
        o_raw_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      opr_r  <= i_opr;
      quot_r <= '0;
      rem_r  <= '0;
    end else if (running) begin
      // quotient bits arrive msb first and shift in from the bottom
      quot_r <= {quot_r[XLEN-2:0], fits};
      rem_r  <= fits ? diff[XLEN-1:0] : trial[XLEN-1:0];
    end
  end

  always_comb begin
    o_raw.op        = opr_r.op;
    o_raw.quotient  = quot_r;
    o_raw.remainder = rem_r;
    o_raw.neg_quot  = opr_r.neg_quot;
    o_raw.neg_rem   = opr_r.neg_rem;
    o_raw.div_zero  = opr_r.div_zero;
    o_raw.overflow  = opr_r.overflow;
    o_raw.dividend  = opr_r.dividend;
  end

endmodule

// ==== rtl/div_result_fixup.sv ====
`timescale 1ns/100ps

module div_result_fixup
  import div_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_rst_n,
  input  logic        i_raw_valid,
  output logic        o_raw_ready,
  input  div_raw_t    i_raw,
  output logic        o_res_valid,
  input  logic        i_res_ready,
  output div_result_t o_res
);

  logic [XLEN-1:0] quot_s, rem_s;
  logic [XLEN-1:0] quot_f, rem_f;
  logic [XLEN-1:0] pick;
  div_result_t     res_next;
  logic            accept;

  assign o_raw_ready = !o_res_valid || i_res_ready;
  assign accept      = i_raw_valid && o_raw_ready;

  assign quot_s = i_raw.neg_quot ? (~i_raw.quotient + 1'b1) : i_raw.quotient;
  assign rem_s  = i_raw.neg_rem ? (~i_raw.remainder + 1'b1) : i_raw.remainder;

  // RISC-V gives defined results instead of traps for these two cases
  always_comb begin
    quot_f = quot_s;
    rem_f  = rem_s;
    if (i_raw.div_zero) begin
      quot_f = '1;
      rem_f  = i_raw.dividend;
    end else if (i_raw.overflow) begin
      quot_f = i_raw.dividend;
      rem_f  = '0;
    end
  end

  assign pick = i_raw.op.want_rem ? rem_f : quot_f;

  // word results are always sign-extended from bit 31, even for DIVUW and REMUW
  assign res_next = i_raw.op.is_word ?
                    {{(XLEN-WORD_LEN){pick[WORD_LEN-1]}}, pick[WORD_LEN-1:0]} :
                    pick;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_res_valid <= 1'b0;
    end else if (accept) begin
      o_res_valid <= 1'b1;
    end else if (i_res_ready) begin
      o_res_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_res <= res_next;
    end
  end

endmodule

// ==== rtl/div_unit_top.sv ====
`timescale 1ns/100ps

module div_unit_top
  import div_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic [AXIL_AW-1:0] i_awaddr,
  input  logic               i_awvalid,
  output logic               o_awready,
  input  logic [AXIL_DW-1:0] i_wdata,
  input  logic [3:0]         i_wstrb,
  input  logic               i_wvalid,
  output logic               o_wready,
  output logic [1:0]         o_bresp,
  output logic               o_bvalid,
  input  logic               i_bready,
  input  logic [AXIL_AW-1:0] i_araddr,
  input  logic               i_arvalid,
  output logic               o_arready,
  output logic [AXIL_DW-1:0] o_rdata,
  output logic [1:0]         o_rresp,
  output logic               o_rvalid,
  input  logic               i_rready
);

  logic          req_valid, req_ready;
  div_req_t      req;
  logic          opr_valid, opr_ready;
  div_operands_t opr;
  logic          raw_valid, raw_ready;
  div_raw_t      raw;
  logic          res_valid, res_ready;
  div_result_t   res;

  div_axil_regs u_div_axil_regs (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_awaddr    (i_awaddr),
    .i_awvalid   (i_awvalid),
    .o_awready   (o_awready),
    .i_wdata     (i_wdata),
    .i_wstrb     (i_wstrb),
    .i_wvalid    (i_wvalid),
    .o_wready    (o_wready),
    .o_bresp     (o_bresp),
    .o_bvalid    (o_bvalid),
    .i_bready    (i_bready),
    .i_araddr    (i_araddr),
    .i_arvalid   (i_arvalid),
    .o_arready   (o_arready),
    .o_rdata     (o_rdata),
    .o_rresp     (o_rresp),
    .o_rvalid    (o_rvalid),
    .i_rready    (i_rready),
    .o_req_valid (req_valid),
    .i_req_ready (req_ready),
    .o_req       (req),
    .i_res_valid (res_valid),
    .o_res_ready (res_ready),
    .i_res       (res)
  );

  div_operand_prep u_div_operand_prep (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_req_valid (req_valid),
    .o_req_ready (req_ready),
    .i_req       (req),
    .o_opr_valid (opr_valid),
    .i_opr_ready (opr_ready),
    .o_opr       (opr)
  );

  div_iter_core u_div_iter_core (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_opr_valid (opr_valid),
    .o_opr_ready (opr_ready),
    .i_opr       (opr),
    .o_raw_valid (raw_valid),
    .i_raw_ready (raw_ready),
    .o_raw       (raw)
  );

  div_result_fixup u_div_result_fixup (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_raw_valid (raw_valid),
    .o_raw_ready (raw_ready),
    .i_raw       (raw),
    .o_res_valid (res_valid),
    .i_res_ready (res_ready),
    .o_res       (res)
  );

endmodule

// ==== verification/tb_axil_tasks.svh ====
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// AXI4-Lite master tasks, entered a short delay after a rising edge
// handshakes are sampled at the falling edge where every signal is settled

task automatic write_reg(input logic [AXIL_AW-1:0] addr, input logic [AXIL_DW-1:0] data);
  int cycles;
  cycles  = 0;
  awaddr  = addr;
  wdata   = data;
  wstrb   = 4'hF;
  awvalid = 1'b1;
  wvalid  = 1'b1;
  @(negedge clk);
  while (!(awready && wready)) begin
    cycles++;
    if (cycles > HS_TIMEOUT) begin
      stop_on_failure("timeout waiting for the write address and data handshake");
    end else begin
      @(negedge clk);
    end
  end
  @(posedge clk);
  #DRIVE_DLY;
  awvalid = 1'b0;
  wvalid  = 1'b0;
  bready  = 1'b1;
  cycles  = 0;
  @(negedge clk);
  while (!bvalid) begin
    cycles++;
    if (cycles > HS_TIMEOUT) begin
      stop_on_failure("timeout waiting for the write response");
    end else begin
      @(negedge clk);
    end
  end
  check_resp($sformatf("write response at %h", addr), RESP_OKAY, bresp);
  @(posedge clk);
  #DRIVE_DLY;
  bready = 1'b0;
endtask

task automatic read_reg(input logic [AXIL_AW-1:0] addr, output logic [AXIL_DW-1:0] data);
  int cycles;
  cycles  = 0;
  araddr  = addr;
  arvalid = 1'b1;
  @(negedge clk);
  while (!arready) begin
    cycles++;
    if (cycles > HS_TIMEOUT) begin
      stop_on_failure("timeout waiting for the read address handshake");
    end else begin
      @(negedge clk);
    end
  end
  @(posedge clk);
  #DRIVE_DLY;
  arvalid = 1'b0;
  rready  = 1'b1;
  cycles  = 0;
  @(negedge clk);
  while (!rvalid) begin
    cycles++;
    if (cycles > HS_TIMEOUT) begin
      stop_on_failure("timeout waiting for the read data");
    end else begin
      @(negedge clk);
    end
  end
  check_resp($sformatf("read response at %h", addr), RESP_OKAY, rresp);
  data = rdata;
  @(posedge clk);
  #DRIVE_DLY;
  rready = 1'b0;
endtask

`endif

// ==== verification/tb_div_unit_top.sv ====
`timescale 1ns/100ps

module tb_div_unit_top
  import div_pkg::*;
();

  localparam int DRIVE_DLY  = 10;
  localparam int HS_TIMEOUT = 20;
  localparam int POLL_LIMIT = 100;

  // expected STATUS words built from the documented bit positions
  localparam logic [AXIL_DW-1:0] STATUS_IDLE   = '0;
  localparam logic [AXIL_DW-1:0] STATUS_BUSY   = 32'h1 << ST_BUSY_BIT;
  localparam logic [AXIL_DW-1:0] STATUS_DONE   = 32'h1 << ST_DONE_BIT;
  localparam logic [AXIL_DW-1:0] STATUS_REJECT = 32'h1 << ST_REJECT_BIT;

  // AXI OKAY response code
  localparam logic [1:0] RESP_OKAY = 2'b00;

  logic               clk, rst_n;
  logic [AXIL_AW-1:0] awaddr, araddr;
  logic [AXIL_DW-1:0] wdata, rdata;
  logic [3:0]         wstrb;
  logic [1:0]         bresp, rresp;
  logic               awvalid, awready, wvalid, wready, bvalid, bready;
  logic               arvalid, arready, rvalid, rready;

  div_unit_top u_div_unit_top (
    .i_clk     (clk),
    .i_rst_n   (rst_n),
    .i_awaddr  (awaddr),
    .i_awvalid (awvalid),
    .o_awready (awready),
    .i_wdata   (wdata),
    .i_wstrb   (wstrb),
    .i_wvalid  (wvalid),
    .o_wready  (wready),
    .o_bresp   (bresp),
    .o_bvalid  (bvalid),
    .i_bready  (bready),
    .i_araddr  (araddr),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .o_rdata   (rdata),
    .o_rresp   (rresp),
    .o_rvalid  (rvalid),
    .i_rready  (rready)
  );

  always #50 clk = ~clk;

  task automatic stop_on_failure(input string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic check_result(input string name, input div_result_t expected,
                              input div_result_t actual);
    if (actual !== expected) begin
      stop_on_failure($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_status(input string name, input logic [AXIL_DW-1:0] expected,
                              input logic [AXIL_DW-1:0] actual);
    if (actual !== expected) begin
      stop_on_failure($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] expected,
                            input logic [1:0] actual);
    if (actual !== expected) begin
      stop_on_failure($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
    end
  endtask

  `include "tb_axil_tasks.svh"

  // CTRL word with the op in bits 2:0 and the start bit set
  function automatic logic [AXIL_DW-1:0] ctrl_word(input div_op_t op);
    logic [AXIL_DW-1:0] w;
    w = '0;
    w[$bits(div_op_t)-1:0] = op;
    w[CTRL_START_BIT] = 1'b1;
    return w;
  endfunction

  task automatic start_op(input div_op_t op, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b);
    write_reg(REG_A_LO, a[AXIL_DW-1:0]);
    write_reg(REG_A_HI, a[XLEN-1:AXIL_DW]);
    write_reg(REG_B_LO, b[AXIL_DW-1:0]);
    write_reg(REG_B_HI, b[XLEN-1:AXIL_DW]);
    write_reg(REG_CTRL, ctrl_word(op));
  endtask

  task automatic read_result(output div_result_t res);
    logic [AXIL_DW-1:0] lo, hi;
    read_reg(REG_RES_LO, lo);
    read_reg(REG_RES_HI, hi);
    res = {hi, lo};
  endtask

  // polls STATUS until done, then expects done alone
  task automatic wait_done(input string name);
    logic [AXIL_DW-1:0] st;
    int polls;
    polls = 0;
    read_reg(REG_STATUS, st);
    while (!st[ST_DONE_BIT]) begin
      polls++;
      if (polls > POLL_LIMIT) begin
        stop_on_failure($sformatf("timeout waiting for done in %s", name));
      end else begin
        read_reg(REG_STATUS, st);
      end
    end
    check_status({name, " status at done"}, STATUS_DONE, st);
  endtask

  initial begin
    int               fd;
    int               code;
    int               n_vec;
    logic [8*128-1:0] line_buf;
    logic [2:0]       op_bits;
    logic [XLEN-1:0]  a, b, last_a, last_b;
    div_result_t      exp_res, res, last_exp;
    div_op_t          last_op;
    logic [AXIL_DW-1:0] st;
    string            name;

    clk     = 1'b0;
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    last_op  = '0;
    last_a   = '0;
    last_b   = '0;
    last_exp = '0;
    n_vec    = 0;
    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;

    read_reg(REG_STATUS, st);
    check_status("status after reset", STATUS_IDLE, st);
    read_result(res);
    check_result("result after reset", '0, res);

    fd = $fopen("verification/div_input_vectors.txt", "r");
    if (fd == 0) begin
      stop_on_failure("could not open verification/div_input_vectors.txt");
    end
    line_buf = '0;
    code = $fgets(line_buf, fd);
    while (code != 0) begin
      // comment lines do not scan as four hex fields and are skipped
      if ($sscanf(line_buf, "%h %h %h %h", op_bits, a, b, exp_res) == 4) begin
        n_vec++;
        name = $sformatf("vector %0d op %0h", n_vec, op_bits);
        start_op(div_op_t'(op_bits), a, b);
        read_reg(REG_STATUS, st);
        check_status({name, " status after start"}, STATUS_BUSY, st);
        wait_done(name);
        read_result(res);
        check_result(name, exp_res, res);
        last_op  = div_op_t'(op_bits);
        last_a   = a;
        last_b   = b;
        last_exp = exp_res;
      end
      line_buf = '0;
      code = $fgets(line_buf, fd);
    end
    $fclose(fd);
    if (n_vec == 0) begin
      stop_on_failure("the vector file holds no operations");
    end

    // rerun the last vector and disturb it with a new operand and a second start
    start_op(last_op, last_a, last_b);
    write_reg(REG_A_LO, ~last_a[AXIL_DW-1:0]);
    write_reg(REG_CTRL, ctrl_word({last_op.is_signed, last_op.is_word, !last_op.want_rem}));
    read_reg(REG_STATUS, st);
    check_status("status after start while busy", STATUS_BUSY | STATUS_REJECT, st);
    read_reg(REG_STATUS, st);
    check_status("status after reject was read", STATUS_BUSY, st);
    wait_done("rejected start run");
    read_result(res);
    check_result("result after rejected start", last_exp, res);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== verification/div_input_vectors.txt ====
# columns: op a b expected, hex; op bits are is_signed, is_word, want_rem
# op 4 DIV, 0 DIVU, 5 REM, 1 REMU, 6 DIVW, 2 DIVUW, 7 REMW, 3 REMUW
4 0000000000000064 0000000000000007 000000000000000E
4 FFFFFFFFFFFFFF9C 0000000000000007 FFFFFFFFFFFFFFF2
5 FFFFFFFFFFFFFF9C 0000000000000007 FFFFFFFFFFFFFFFE
4 0000000000000064 FFFFFFFFFFFFFFF9 FFFFFFFFFFFFFFF2
5 FFFFFFFFFFFFFF9C FFFFFFFFFFFFFFF9 FFFFFFFFFFFFFFFE
0 FFFFFFFFFFFFFFFF 0000000000000010 0FFFFFFFFFFFFFFF
0 8000000000000000 0000000000000003 2AAAAAAAAAAAAAAA
1 8000000000000000 0000000000000003 0000000000000002
4 8000000000000000 0000000000000003 D555555555555556
0 123456789ABCDEF0 0000000000000100 00123456789ABCDE
4 0000000080000000 FFFFFFFFFFFFFFFF FFFFFFFF80000000
6 DEADBEEFFFFFFF9C 1234567800000007 FFFFFFFFFFFFFFF2
7 DEADBEEFFFFFFF9C 1234567800000007 FFFFFFFFFFFFFFFE
2 FFFFFFFFFFFFFFFE AAAAAAAA00000001 FFFFFFFFFFFFFFFE
2 0000000180000000 0000000100000002 0000000040000000
3 5555555580000005 FFFFFFFF80000000 0000000000000005
3 00000009FFFFFFF0 00000000FFFFFFF1 FFFFFFFFFFFFFFF0
4 0000000000000123 0000000000000000 FFFFFFFFFFFFFFFF
5 FFFFFFFFFFFFFF9C 0000000000000000 FFFFFFFFFFFFFF9C
0 0000000000000005 0000000000000000 FFFFFFFFFFFFFFFF
1 8000000000000000 0000000000000000 8000000000000000
4 8000000000000000 FFFFFFFFFFFFFFFF 8000000000000000
5 8000000000000000 FFFFFFFFFFFFFFFF 0000000000000000
6 FFFF000000000007 FFFFFFFF00000000 FFFFFFFFFFFFFFFF
7 1234567880000001 0000000100000000 FFFFFFFF80000001
2 0000000000001234 1111111100000000 FFFFFFFFFFFFFFFF
3 0000000180000001 0000000000000000 FFFFFFFF80000001
6 0000000780000000 00000003FFFFFFFF FFFFFFFF80000000
7 0000000780000000 00000003FFFFFFFF 0000000000000000

// ==== flist.f ====
+incdir+verification
rtl/div_pkg.sv
rtl/div_axil_regs.sv
rtl/div_operand_prep.sv
rtl/div_iter_core.sv
rtl/div_result_fixup.sv
rtl/div_unit_top.sv
verification/tb_div_unit_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_div_unit_top \
  -f flist.f -o tb_div_unit_top
./obj_dir/tb_div_unit_top
